/* common/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W     = 16;
    localparam int WORD_W     = 32;
    localparam int STRB_W     = WORD_W / 8;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int LINES      = 16;

    // Address split, tag | index | word | byte
    localparam int OFFSET_W = $clog2(LINE_W / 8);
    localparam int INDEX_W  = $clog2(LINES);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LADDR_W  = TAG_W + INDEX_W;
    localparam int WSEL_W   = $clog2(LINE_WORDS);  // Word select inside a line

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        FILL
    } miss_state_t;

endpackage

/* common/miss_if.sv */
`timescale 1ns/1ps

interface miss_if;

    logic                             miss;
    logic [dcache_pkg::TAG_W-1:0]     miss_tag;
    logic [dcache_pkg::INDEX_W-1:0]   miss_index;
    logic [dcache_pkg::TAG_W-1:0]     victim_tag;
    logic                             victim_dirty;  // Already qualified by the valid bit
    logic [dcache_pkg::LINE_W-1:0]    victim_line;
    logic                             fill_done;
    logic [dcache_pkg::LINE_W-1:0]    fill_line;

    modport lookup (
        output miss, miss_tag, miss_index, victim_tag, victim_dirty, victim_line,
        input  fill_done, fill_line
    );

    modport ctrl (
        input  miss, miss_tag, miss_index, victim_tag, victim_dirty, victim_line,
        output fill_done, fill_line
    );

endinterface

/* storage/line_ram.sv */
`timescale 1ns/1ps

module line_ram #(
    parameter int WIDTH = 8
) (
    input  logic                           CLK,
    input  logic                           wren,
    input  logic [dcache_pkg::INDEX_W-1:0] waddr,
    input  logic [WIDTH-1:0]               wdata,
    input  logic [dcache_pkg::INDEX_W-1:0] raddr,
    output logic [WIDTH-1:0]               rdata
);

    logic [WIDTH-1:0] mem [dcache_pkg::LINES];

    always_ff @(posedge CLK) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // Read before write on the same index
    end

endmodule

/* storage/state_bits.sv */
`timescale 1ns/1ps

module state_bits (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           wren,
    input  logic [dcache_pkg::INDEX_W-1:0] waddr,
    input  logic                           wbit,
    input  logic [dcache_pkg::INDEX_W-1:0] raddr,
    output logic                           rbit
);

    logic [dcache_pkg::LINES-1:0] bits;

    always_ff @(posedge CLK) begin
        if (RST) begin
            bits <= '0;
        end else if (wren) begin
            bits[waddr] <= wbit;
        end
    end

    // Same one-cycle read as line_ram so every array lines up in stage 2
    always_ff @(posedge CLK) begin
        if (RST) begin
            rbit <= 1'b0;
        end else begin
            rbit <= bits[raddr];
        end
    end

endmodule

/* lookup/dcache_lookup.sv */
`timescale 1ns/1ps

module dcache_lookup (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [dcache_pkg::ADDR_W-1:0]  req_addr,
    input  logic [dcache_pkg::WORD_W-1:0]  req_wdata,
    input  logic [dcache_pkg::STRB_W-1:0]  req_wstrb,
    output logic                           rsp_valid,
    output logic [dcache_pkg::WORD_W-1:0]  rsp_rdata,
    output logic [dcache_pkg::INDEX_W-1:0] rd_index,
    input  logic [dcache_pkg::LINE_W-1:0]  data_rd,
    input  logic [dcache_pkg::TAG_W-1:0]   tag_rd,
    input  logic                           valid_rd,
    input  logic                           dirty_rd,
    output logic                           st_wren,
    output logic [dcache_pkg::INDEX_W-1:0] st_index,
    output logic [dcache_pkg::LINE_W-1:0]  st_line,
    miss_if.lookup                         mif
);

    logic                          s1_valid;
    logic                          s1_write;
    logic [dcache_pkg::ADDR_W-1:0] s1_addr;
    logic [dcache_pkg::WORD_W-1:0] s1_wdata;
    logic [dcache_pkg::STRB_W-1:0] s1_wstrb;
    logic                          s2_valid;
    logic                          s2_new;
    logic                          s2_write;
    logic [dcache_pkg::ADDR_W-1:0] s2_addr;
    logic [dcache_pkg::WORD_W-1:0] s2_wdata;
    logic [dcache_pkg::STRB_W-1:0] s2_wstrb;
    logic [dcache_pkg::WSEL_W-1:0] s2_word;
    logic                          miss_q;
    logic                          fill_q;
    logic                          fwd_q;
    logic [dcache_pkg::LINE_W-1:0] fwd_line;
    logic [dcache_pkg::LINE_W-1:0] line_s2;
    logic [dcache_pkg::LINE_W-1:0] merged;
    logic                          hit_now;
    logic                          advance;

    // Array outputs only describe stage 2 in its first cycle, later they follow stage 1
    assign s2_word   = s2_addr[dcache_pkg::OFFSET_W-1 -: dcache_pkg::WSEL_W];
    assign line_s2   = fill_q ? mif.fill_line : (fwd_q ? fwd_line : data_rd);
    assign hit_now   = valid_rd && (tag_rd == s2_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W]);
    assign mif.miss  = s2_valid && ((s2_new && !hit_now) || miss_q);
    assign advance   = !mif.miss;
    assign req_ready = advance;
    assign rsp_valid = s2_valid && ((s2_new && hit_now) || fill_q);
    assign rsp_rdata = line_s2[s2_word*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

    assign rd_index = s1_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign st_wren  = rsp_valid && s2_write;
    assign st_index = s2_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign st_line  = merged;

    assign mif.miss_tag     = s2_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign mif.miss_index   = st_index;
    assign mif.victim_tag   = tag_rd;
    assign mif.victim_dirty = valid_rd && (fwd_q || dirty_rd);  // A forwarded line is dirty
    assign mif.victim_line  = line_s2;

    always_comb begin
        merged = line_s2;
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (s2_wstrb[b]) begin
                merged[s2_word*dcache_pkg::WORD_W + b*8 +: 8] = s2_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s2_new   <= 1'b0;
            miss_q   <= 1'b0;
            fill_q   <= 1'b0;
            fwd_q    <= 1'b0;
        end else begin
            fill_q <= mif.fill_done;
            fwd_q  <= st_wren && (st_index == rd_index);  // Stage 1 read missed this write
            s2_new <= advance;
            if (advance) begin
                s1_valid <= req_valid;
                s2_valid <= s1_valid;
            end
            if (mif.fill_done) begin
                miss_q <= 1'b0;
            end else if (s2_valid && s2_new && !hit_now) begin
                miss_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (advance) begin
            s1_write <= req_write;
            s1_addr  <= req_addr;
            s1_wdata <= req_wdata;
            s1_wstrb <= req_wstrb;
            s2_write <= s1_write;
            s2_addr  <= s1_addr;
            s2_wdata <= s1_wdata;
            s2_wstrb <= s1_wstrb;
        end
        fwd_line <= merged;
    end

    a_miss_after_fill: assert property (@(posedge CLK) disable iff (RST)
        $rose(mif.miss) |-> !mif.fill_done)
        else $error("New miss raised during a fill");

    // Both stages hold their requests while a miss is pending
    a_stall_on_miss: assert property (@(posedge CLK) disable iff (RST)
        mif.miss |=> $stable(s1_addr) && $stable(s2_addr))
        else $error("Request accepted while a miss is pending");

endmodule

/* design/dcache_miss_ctrl.sv */
`timescale 1ns/1ps

module dcache_miss_ctrl (
    input  logic                           CLK,
    input  logic                           RST,
    miss_if.ctrl                           mif,
    output logic                           l2_req_valid,
    output logic [dcache_pkg::LADDR_W-1:0] l2_req_addr,
    input  logic                           l2_rsp_valid,
    input  logic [dcache_pkg::LINE_W-1:0]  l2_rsp_line,
    output logic                           l2_wb_valid,
    output logic [dcache_pkg::LADDR_W-1:0] l2_wb_addr,
    output logic [dcache_pkg::LINE_W-1:0]  l2_wb_line,
    input  logic                           l2_wb_done,
    output logic                           fill_wren,
    output logic [dcache_pkg::INDEX_W-1:0] fill_index,
    output logic [dcache_pkg::TAG_W-1:0]   fill_tag
);

    dcache_pkg::miss_state_t       state;
    logic [dcache_pkg::LINE_W-1:0] fill_line_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= dcache_pkg::IDLE;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (mif.miss) begin
                        state <= mif.victim_dirty ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (l2_wb_done) begin
                        state <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::REFILL: begin
                    if (l2_rsp_valid) begin
                        state <= dcache_pkg::FILL;
                    end
                end
                default: state <= dcache_pkg::IDLE;  // FILL is a single cycle
            endcase
        end
    end

    // Victim is only valid in the first miss cycle, so capture it on the way out of IDLE
    always_ff @(posedge CLK) begin
        if (state == dcache_pkg::IDLE && mif.miss) begin
            l2_wb_addr <= {mif.victim_tag, mif.miss_index};
            l2_wb_line <= mif.victim_line;
        end
        if (state == dcache_pkg::REFILL && l2_rsp_valid) begin
            fill_line_q <= l2_rsp_line;
        end
    end

    assign l2_wb_valid   = (state == dcache_pkg::WRITEBACK);
    assign l2_req_valid  = (state == dcache_pkg::REFILL);
    assign l2_req_addr   = {mif.miss_tag, mif.miss_index};  // Stage 2 is frozen meanwhile
    assign fill_wren     = (state == dcache_pkg::FILL);
    assign fill_index    = mif.miss_index;
    assign fill_tag      = mif.miss_tag;
    assign mif.fill_done = fill_wren;
    assign mif.fill_line = fill_line_q;  // Held into the cycle after fill_done

    a_l2_one_request: assert property (@(posedge CLK) disable iff (RST)
        !(l2_req_valid && l2_wb_valid))
        else $error("Write-back and refill requested together");

    a_wb_addr_stable: assert property (@(posedge CLK) disable iff (RST)
        l2_wb_valid && $past(l2_wb_valid) |-> $stable(l2_wb_addr))
        else $error("Write-back address changed while waiting");

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [dcache_pkg::ADDR_W-1:0]  req_addr,
    input  logic [dcache_pkg::WORD_W-1:0]  req_wdata,
    input  logic [dcache_pkg::STRB_W-1:0]  req_wstrb,
    output logic                           rsp_valid,
    output logic [dcache_pkg::WORD_W-1:0]  rsp_rdata,
    output logic                           l2_req_valid,
    output logic [dcache_pkg::LADDR_W-1:0] l2_req_addr,
    input  logic                           l2_rsp_valid,
    input  logic [dcache_pkg::LINE_W-1:0]  l2_rsp_line,
    output logic                           l2_wb_valid,
    output logic [dcache_pkg::LADDR_W-1:0] l2_wb_addr,
    output logic [dcache_pkg::LINE_W-1:0]  l2_wb_line,
    input  logic                           l2_wb_done
);

    logic [dcache_pkg::INDEX_W-1:0] rd_index;
    logic [dcache_pkg::LINE_W-1:0]  data_rd;
    logic [dcache_pkg::TAG_W-1:0]   tag_rd;
    logic                           valid_rd;
    logic                           dirty_rd;
    logic                           st_wren;
    logic [dcache_pkg::INDEX_W-1:0] st_index;
    logic [dcache_pkg::LINE_W-1:0]  st_line;
    logic                           fill_wren;
    logic [dcache_pkg::INDEX_W-1:0] fill_index;
    logic [dcache_pkg::TAG_W-1:0]   fill_tag;
    logic                           data_wren;
    logic [dcache_pkg::INDEX_W-1:0] data_waddr;
    logic [dcache_pkg::LINE_W-1:0]  data_wdata;

    miss_if mif ();

    // Fills take priority on the shared write port because stores stall during a miss
    assign data_wren  = fill_wren | st_wren;
    assign data_waddr = st_index;  // Stage 2 index serves fills and stores alike
    assign data_wdata = fill_wren ? mif.fill_line : st_line;

    dcache_lookup u_lookup (
        .CLK(CLK), .RST(RST),
        .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
        .rd_index(rd_index), .data_rd(data_rd), .tag_rd(tag_rd),
        .valid_rd(valid_rd), .dirty_rd(dirty_rd),
        .st_wren(st_wren), .st_index(st_index), .st_line(st_line),
        .mif(mif)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .CLK(CLK), .RST(RST), .mif(mif),
        .l2_req_valid(l2_req_valid), .l2_req_addr(l2_req_addr),
        .l2_rsp_valid(l2_rsp_valid), .l2_rsp_line(l2_rsp_line),
        .l2_wb_valid(l2_wb_valid), .l2_wb_addr(l2_wb_addr),
        .l2_wb_line(l2_wb_line), .l2_wb_done(l2_wb_done),
        .fill_wren(fill_wren), .fill_index(fill_index), .fill_tag(fill_tag)
    );

    line_ram #(.WIDTH(dcache_pkg::LINE_W)) u_data_ram (
        .CLK(CLK), .wren(data_wren), .waddr(data_waddr), .wdata(data_wdata),
        .raddr(rd_index), .rdata(data_rd)
    );

    line_ram #(.WIDTH(dcache_pkg::TAG_W)) u_tag_ram (
        .CLK(CLK), .wren(fill_wren), .waddr(fill_index), .wdata(fill_tag),
        .raddr(rd_index), .rdata(tag_rd)
    );

    state_bits u_valid_bits (
        .CLK(CLK), .RST(RST), .wren(fill_wren), .waddr(fill_index), .wbit(1'b1),
        .raddr(rd_index), .rbit(valid_rd)
    );

    state_bits u_dirty_bits (
        .CLK(CLK), .RST(RST), .wren(data_wren), .waddr(data_waddr), .wbit(~fill_wren),
        .raddr(rd_index), .rbit(dirty_rd)
    );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

endmodule

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam int N_RANDOM   = 300;
    localparam int N_REQS     = N_RANDOM + 7;
    localparam int TIMEOUT_NS = (N_REQS * 40 + 10) * 20;

    typedef struct packed {
        logic         is_wb;
        logic [11:0]  laddr;
        logic [127:0] line;
    } l2_event_t;

    typedef struct packed {
        logic        is_load;
        logic        exact;  // Hit with no miss ahead of it, so the latency is fixed
        logic [31:0] data;
        logic [31:0] acc_cycle;
    } rsp_event_t;

    logic                           CLK;
    logic                           RST;
    logic                           req_valid;
    logic                           req_ready;
    logic                           req_write;
    logic [dcache_pkg::ADDR_W-1:0]  req_addr;
    logic [dcache_pkg::WORD_W-1:0]  req_wdata;
    logic [dcache_pkg::STRB_W-1:0]  req_wstrb;
    logic                           rsp_valid;
    logic [dcache_pkg::WORD_W-1:0]  rsp_rdata;
    logic                           l2_req_valid;
    logic [dcache_pkg::LADDR_W-1:0] l2_req_addr;
    logic                           l2_rsp_valid;
    logic [dcache_pkg::LINE_W-1:0]  l2_rsp_line;
    logic                           l2_wb_valid;
    logic [dcache_pkg::LADDR_W-1:0] l2_wb_addr;
    logic [dcache_pkg::LINE_W-1:0]  l2_wb_line;
    logic                           l2_wb_done;

    int           seed;
    int           accepted = 0;
    int           answered = 0;
    logic [31:0]  cycle_count;
    logic [7:0]   ref_mem [65536];
    logic [127:0] l2_mem [logic [11:0]];
    logic [7:0]   tag_of [16];
    logic [15:0]  valid_of = '0;
    logic [15:0]  dirty_of = '0;
    logic         last_hit = 1'b1;
    l2_event_t    l2_q [$];
    rsp_event_t   rsp_q [$];

    tb_clock u_clock (.CLK(CLK));

    dcache_top u_dcache_top (.*);

    function automatic logic [7:0] default_byte(input logic [15:0] a);
        return (a[7:0] * 8'd3) ^ a[15:8] ^ 8'hA5;
    endfunction

    function automatic logic [127:0] default_line(input logic [11:0] laddr);
        logic [127:0] line;
        for (int o = 0; o < 16; o++) begin
            line[o*8 +: 8] = default_byte({laddr, o[3:0]});
        end
        return line;
    endfunction

    function automatic logic [127:0] ref_line(input logic [11:0] laddr);
        logic [127:0] line;
        for (int o = 0; o < 16; o++) begin
            line[o*8 +: 8] = ref_mem[{laddr, o[3:0]}];
        end
        return line;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic expect_quiet();
        check(128'(rsp_valid), 128'(0), "rsp_valid low around reset");
        check(128'(l2_req_valid), 128'(0), "l2_req_valid low around reset");
        check(128'(l2_wb_valid), 128'(0), "l2_wb_valid low around reset");
        check(128'(req_ready), 128'(1), "req_ready high after reset");
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_request(input logic write, input logic [15:0] addr,
                                input logic [31:0] data, input logic [3:0] strb);
        logic taken;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        taken     = 1'b0;
        while (!taken) begin
            @(posedge CLK);
            taken = req_ready;
            @(negedge CLK);
        end
        req_valid = 1'b0;
    endtask

    // The model runs in acceptance order, which is the order the cache serves requests
    task automatic record_accept();
        rsp_event_t ev;
        logic [3:0] idx;
        logic [7:0] tag;
        logic       hit;
        idx = req_addr[7:4];
        tag = req_addr[15:8];
        hit = valid_of[idx] && (tag_of[idx] == tag);
        if (!hit) begin
            if (valid_of[idx] && dirty_of[idx]) begin
                l2_q.push_back({1'b1, tag_of[idx], idx, ref_line({tag_of[idx], idx})});
            end
            l2_q.push_back({1'b0, req_addr[15:4], 128'(0)});
            valid_of[idx] = 1'b1;
            dirty_of[idx] = 1'b0;
            tag_of[idx]   = tag;
        end
        if (req_write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_wstrb[b[1:0]]) begin
                    ref_mem[{req_addr[15:2], b[1:0]}] = req_wdata[b*8 +: 8];
                end
            end
            dirty_of[idx] = 1'b1;
        end
        ev.is_load   = !req_write;
        ev.exact     = hit && (last_hit || rsp_q.size() == 0);
        ev.data      = {ref_mem[{req_addr[15:2], 2'd3}], ref_mem[{req_addr[15:2], 2'd2}],
                        ref_mem[{req_addr[15:2], 2'd1}], ref_mem[{req_addr[15:2], 2'd0}]};
        ev.acc_cycle = cycle_count;
        rsp_q.push_back(ev);
        last_hit = hit;
        accepted++;
    endtask

    task automatic take_response();
        rsp_event_t want;
        if (rsp_valid) begin
            if (rsp_q.size() == 0) begin
                $display("Response at %0t ns with no request outstanding", $time);
                abort_run();
            end else begin
                want = rsp_q.pop_front();
                answered++;
                if (want.is_load) begin
                    check(128'(rsp_rdata), 128'(want.data), "load data");
                end
                if (want.exact) begin
                    check(128'(cycle_count), 128'(want.acc_cycle + 2), "hit response latency");
                end
            end
        end else if (rsp_q.size() != 0 && rsp_q[0].exact &&
                     cycle_count == rsp_q[0].acc_cycle + 2) begin
            check(128'(rsp_valid), 128'(1), "hit response 2 cycles after acceptance");
        end
    endtask

    always @(posedge CLK) begin
        if (RST) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    always @(posedge CLK) begin
        if (!RST) begin
            take_response();  // First, so the queue is current when this edge also accepts
            if (req_valid && req_ready) begin
                record_accept();
            end
        end
    end

    initial begin : l2_model
        l2_event_t   want;
        logic [31:0] r;
        logic [11:0] laddr;
        l2_rsp_valid = 1'b0;
        l2_rsp_line  = '0;
        l2_wb_done   = 1'b0;
        forever begin
            @(posedge CLK);
            if (!RST && (l2_wb_valid || l2_req_valid)) begin
                if (l2_q.size() == 0) begin
                    $display("L2 transfer at %0t ns that no miss explains", $time);
                    abort_run();
                end else begin
                    want  = l2_q.pop_front();
                    laddr = l2_wb_valid ? l2_wb_addr : l2_req_addr;
                    check(128'(l2_wb_valid), 128'(want.is_wb), "write-back before refill");
                    check(128'(laddr), 128'(want.laddr), "L2 line address");
                    if (l2_wb_valid) begin
                        check(l2_wb_line, want.line, "write-back line");
                        l2_mem[laddr] = l2_wb_line;
                    end
                    r = $random(seed);
                    repeat (r[1:0] + 1) @(negedge CLK);
                    if (want.is_wb) begin
                        l2_wb_done = 1'b1;
                    end else begin
                        l2_rsp_valid = 1'b1;
                        l2_rsp_line  = l2_mem.exists(laddr) ? l2_mem[laddr] : default_line(laddr);
                    end
                    @(negedge CLK);
                    l2_wb_done   = 1'b0;
                    l2_rsp_valid = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [15:0] addr;
        seed      = 32'h5647;
        RST       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a[15:0]] = default_byte(a[15:0]);
        end
        @(posedge CLK);
        repeat (2) begin
            @(negedge CLK);
            expect_quiet();
        end
        @(negedge CLK);
        RST = 1'b0;
        repeat (3) begin
            @(negedge CLK);
            expect_quiet();
        end

        // Cold miss, then stores each followed at once by a load of the same word
        send_request(1'b0, 16'h4320, 32'h0, 4'h0);
        send_request(1'b1, 16'h4324, 32'hDEAD_BEEF, 4'b1011);
        send_request(1'b0, 16'h4324, 32'h0, 4'h0);
        send_request(1'b1, 16'h4328, 32'h1234_5678, 4'b0110);
        send_request(1'b0, 16'h4328, 32'h0, 4'h0);
        send_request(1'b0, 16'h7320, 32'h0, 4'h0);  // Evicts the dirty line at index 2
        send_request(1'b0, 16'h4324, 32'h0, 4'h0);

        // Four tags over four indices, with half the requests staying on the last line
        addr = 16'h4320;
        for (int n = 0; n < N_RANDOM; n++) begin
            r    = $random(seed);
            addr = r[6] ? {addr[15:4], r[5:4], 2'b00}
                        : {2'b01, r[1:0], 4'h3, r[3], 2'b01, r[2], r[5:4], 2'b00};
            if (r[10:9] == 2'd0) begin
                repeat (r[12:11] + 1) @(negedge CLK);
            end
            send_request(r[7], addr, $random(seed), r[16:13]);
        end

        while (rsp_q.size() != 0) begin
            @(posedge CLK);
        end
        repeat (4) @(negedge CLK);
        if (l2_q.size() == 0 && accepted == N_REQS && answered == N_REQS) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Run ended with %0d of %0d requests answered and %0d L2 transfers left",
                     answered, N_REQS, l2_q.size());
            abort_run();
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the cache stopped answering requests", TIMEOUT_NS);
        abort_run();
    end

endmodule

/* dcache_top.f */
common/dcache_pkg.sv
common/miss_if.sv
storage/line_ram.sv
storage/state_bits.sv
lookup/dcache_lookup.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
test/tb_clock.sv
test/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timing --top-module dcache_tb -f dcache_top.f \
    --Mdir "$BUILD_DIR" -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_dcache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
